// File: dcache.f
logic/dcache_pkg.sv
logic/dcache_control.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

// File: logic/dcache.sv
`default_nettype none

module dcache
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	// Processor side
	input  logic  halt,
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	output logic  dhit,
	output word_t dmem_load,
	output logic  flushed,
	// Memory side
	output logic  mem_ren,
	output logic  mem_wen,
	output word_t mem_addr,
	output word_t mem_store,
	input  logic  mem_wait,
	input  word_t mem_load
);

	// Controller strobes
	logic store_en;
	logic fill_en;
	logic fill_last;
	logic word_sel;
	logic flush_wb;
	logic clean_en;
	logic touch;

	// Tag store status
	logic lookup_hit;
	logic victim_dirty;
	logic some_dirty;

	// Slot selection shared with the data store
	logic access_way;
	idx_t wb_idx;
	logic wb_way;

	////////////////////
	// Controller
	////////////////////

	dcache_control u_control (
		.CLK          (CLK),
		.nRST         (nRST),
		.halt         (halt),
		.dmem_ren     (dmem_ren),
		.dmem_wen     (dmem_wen),
		.mem_wait     (mem_wait),
		.lookup_hit   (lookup_hit),
		.victim_dirty (victim_dirty),
		.some_dirty   (some_dirty),
		.dhit         (dhit),
		.flushed      (flushed),
		.mem_ren      (mem_ren),
		.mem_wen      (mem_wen),
		.store_en     (store_en),
		.fill_en      (fill_en),
		.fill_last    (fill_last),
		.word_sel     (word_sel),
		.flush_wb     (flush_wb),
		.clean_en     (clean_en),
		.touch        (touch)
	);

	////////////////////
	// Stores
	////////////////////

	dcache_tag_store u_tag_store (
		.CLK          (CLK),
		.nRST         (nRST),
		.dmem_addr    (dmem_addr),
		.store_en     (store_en),
		.fill_last    (fill_last),
		.word_sel     (word_sel),
		.flush_wb     (flush_wb),
		.clean_en     (clean_en),
		.touch        (touch),
		.mem_wen      (mem_wen),
		.lookup_hit   (lookup_hit),
		.victim_dirty (victim_dirty),
		.some_dirty   (some_dirty),
		.access_way   (access_way),
		.wb_idx       (wb_idx),
		.wb_way       (wb_way),
		.mem_addr     (mem_addr)
	);

	dcache_data_store u_data_store (
		.CLK        (CLK),
		.nRST       (nRST),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.mem_load   (mem_load),
		.store_en   (store_en),
		.fill_en    (fill_en),
		.word_sel   (word_sel),
		.access_way (access_way),
		.wb_idx     (wb_idx),
		.wb_way     (wb_way),
		.dmem_load  (dmem_load),
		.mem_store  (mem_store)
	);

endmodule

`default_nettype wire

// File: logic/dcache_control.sv
`default_nettype none

module dcache_control
	import dcache_pkg::*;
(
	input  logic CLK,
	input  logic nRST,
	input  logic halt,
	input  logic dmem_ren,
	input  logic dmem_wen,
	input  logic mem_wait,
	input  logic lookup_hit,
	input  logic victim_dirty,
	input  logic some_dirty,
	output logic dhit,
	output logic flushed,
	output logic mem_ren,
	output logic mem_wen,
	output logic store_en,
	output logic fill_en,
	output logic fill_last,
	output logic word_sel,
	output logic flush_wb,
	output logic clean_en,
	output logic touch
);

	dcache_state_t state;
	dcache_state_t next_state;
	logic          req;

	// Processor wants a read or a write
	assign req = dmem_ren || dmem_wen;

	////////////////////
	// Hit and strobes
	////////////////////

	// Hit is only served from IDLE
	// A pending halt takes priority over any request
	assign dhit     = (state == IDLE) && !halt && req && lookup_hit;
	assign touch    = dhit;
	assign store_en = dhit && dmem_wen;

	// Fill words land when memory finishes each fetch beat
	assign fill_en   = mem_ren && !mem_wait;
	// Second beat also installs the tag
	assign fill_last = (state == FD2) && !mem_wait;
	// Flushed line goes clean once its second word is out
	assign clean_en  = (state == WBD2) && !mem_wait;

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = DCHK;
				end else if (req && !lookup_hit) begin
					// Dirty victim must reach memory before the fetch
					next_state = victim_dirty ? WB1 : FD1;
				end
			end
			// Every memory beat holds until mem_wait drops
			WB1: begin
				if (!mem_wait) begin
					next_state = WB2;
				end
			end
			WB2: begin
				if (!mem_wait) begin
					next_state = FD1;
				end
			end
			FD1: begin
				if (!mem_wait) begin
					next_state = FD2;
				end
			end
			FD2: begin
				// Back in IDLE the held request hits
				if (!mem_wait) begin
					next_state = IDLE;
				end
			end
			DCHK: begin
				// Nothing dirty left means the flush is done
				next_state = some_dirty ? WBD1 : FLUSHED;
			end
			WBD1: begin
				if (!mem_wait) begin
					next_state = WBD2;
				end
			end
			WBD2: begin
				if (!mem_wait) begin
					next_state = DCHK;
				end
			end
			FLUSHED: begin
				// Only reset leaves this state
				next_state = FLUSHED;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	////////////////////
	// State decode
	////////////////////

	always_comb begin
		mem_ren  = 1'b0;
		mem_wen  = 1'b0;
		word_sel = 1'b0;
		flush_wb = 1'b0;
		flushed  = 1'b0;
		case (state)
			WB1: begin
				mem_wen = 1'b1;
			end
			WB2: begin
				mem_wen  = 1'b1;
				word_sel = 1'b1;
			end
			FD1: begin
				mem_ren = 1'b1;
			end
			FD2: begin
				mem_ren  = 1'b1;
				word_sel = 1'b1;
			end
			WBD1: begin
				mem_wen  = 1'b1;
				flush_wb = 1'b1;
			end
			WBD2: begin
				mem_wen  = 1'b1;
				word_sel = 1'b1;
				flush_wb = 1'b1;
			end
			FLUSHED: begin
				flushed = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/dcache_data_store.sv
`default_nettype none

module dcache_data_store
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	input  word_t mem_load,
	input  logic  store_en,
	input  logic  fill_en,
	input  logic  word_sel,
	input  logic  access_way,
	input  idx_t  wb_idx,
	input  logic  wb_way,
	output word_t dmem_load,
	output word_t mem_store
);

	// Every word of every block
	word_t words [SETS][WAYS][BLK_WORDS];

	idx_t req_idx;
	logic blk_off;

	assign req_idx = dmem_addr[BYTE_OFF_W+1 +: IDX_W];
	assign blk_off = dmem_addr[BYTE_OFF_W];

	////////////////////
	// Word writes
	////////////////////

	// Store and fill never overlap, store is only in IDLE
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					for (int b = 0; b < BLK_WORDS; b++) begin
						words[s][w][b] <= '0;
					end
				end
			end
		end else if (store_en) begin
			// Processor word at its own block offset
			words[req_idx][access_way][blk_off] <= dmem_store;
		end else if (fill_en) begin
			// Memory beat goes to the beat's word of the LRU way
			words[req_idx][access_way][word_sel] <= mem_load;
		end
	end

	////////////////////
	// Word reads
	////////////////////

	// Only meaningful alongside dhit
	assign dmem_load = words[req_idx][access_way][blk_off];

	// Outgoing word for victim or flush write-back
	assign mem_store = words[wb_idx][wb_way][word_sel];

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	////////////////////
	// Cache geometry
	////////////////////

	// Address layout is tag | index | block offset | byte offset
	localparam int WORD_W     = 32;
	localparam int TAG_W      = 26;
	localparam int IDX_W      = 3;
	localparam int BYTE_OFF_W = 2;

	// Two ways of two-word blocks in each of 8 sets
	localparam int SETS      = 8;
	localparam int WAYS      = 2;
	localparam int BLK_WORDS = 2;

	////////////////////
	// Field types
	////////////////////

	// Data word, also used for byte addresses
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [IDX_W-1:0]  idx_t;

	// Controller states
	// WB* write back the victim, FD* fetch the block
	// DCHK and WBD* scan and write back dirty lines on halt
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		WB1     = 4'd1,
		WB2     = 4'd2,
		FD1     = 4'd3,
		FD2     = 4'd4,
		DCHK    = 4'd5,
		WBD1    = 4'd6,
		WBD2    = 4'd7,
		FLUSHED = 4'd8
	} dcache_state_t;

endpackage

`default_nettype wire

// File: logic/dcache_tag_store.sv
`default_nettype none

module dcache_tag_store
	import dcache_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  word_t dmem_addr,
	input  logic  store_en,
	input  logic  fill_last,
	input  logic  word_sel,
	input  logic  flush_wb,
	input  logic  clean_en,
	input  logic  touch,
	input  logic  mem_wen,
	output logic  lookup_hit,
	output logic  victim_dirty,
	output logic  some_dirty,
	output logic  access_way,
	output idx_t  wb_idx,
	output logic  wb_way,
	output word_t mem_addr
);

	tag_t            tags  [SETS][WAYS];
	logic            valid [SETS][WAYS];
	logic            dirty [SETS][WAYS];
	// Set bit names the LRU way
	logic [SETS-1:0] lru;

	tag_t req_tag;
	idx_t req_idx;
	logic hit0;
	logic hit1;
	idx_t scan_idx;
	logic scan_way;

	// Tag and index fields of the request
	assign req_tag = dmem_addr[WORD_W-1 -: TAG_W];
	assign req_idx = dmem_addr[BYTE_OFF_W+1 +: IDX_W];

	////////////////////
	// Lookup
	////////////////////

	assign hit0       = valid[req_idx][0] && (tags[req_idx][0] == req_tag);
	assign hit1       = valid[req_idx][1] && (tags[req_idx][1] == req_tag);
	assign lookup_hit = hit0 || hit1;

	// Hit way on a hit, else the line to replace
	assign access_way   = lookup_hit ? !hit0 : lru[req_idx];
	assign victim_dirty = dirty[req_idx][lru[req_idx]];

	////////////////////
	// Dirty scan
	////////////////////

	// Later sets override earlier ones, so the highest dirty set wins
	// Way 0 is preferred inside a set
	always_comb begin
		scan_idx   = '0;
		scan_way   = 1'b0;
		some_dirty = 1'b0;
		for (int s = 0; s < SETS; s++) begin
			if (dirty[s][0]) begin
				scan_idx   = idx_t'(s);
				scan_way   = 1'b0;
				some_dirty = 1'b1;
			end else if (dirty[s][1]) begin
				scan_idx   = idx_t'(s);
				scan_way   = 1'b1;
				some_dirty = 1'b1;
			end
		end
	end

	// Flush writes the scan slot, a miss writes its own victim
	assign wb_idx = flush_wb ? scan_idx : req_idx;
	assign wb_way = flush_wb ? scan_way : lru[req_idx];

	////////////////////
	// State bits
	////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					valid[s][w] <= 1'b0;
					dirty[s][w] <= 1'b0;
				end
			end
		end else begin
			// Used way becomes MRU, the other one LRU
			if (touch) begin
				lru[req_idx] <= !access_way;
			end
			if (store_en) begin
				dirty[req_idx][access_way] <= 1'b1;
			end
			// New block arrives clean in the LRU way
			if (fill_last) begin
				valid[req_idx][lru[req_idx]] <= 1'b1;
				dirty[req_idx][lru[req_idx]] <= 1'b0;
			end
			if (clean_en) begin
				dirty[wb_idx][wb_way] <= 1'b0;
			end
		end
	end

	// Tag written with the last fill beat
	always_ff @(posedge CLK) begin
		if (fill_last) begin
			tags[req_idx][lru[req_idx]] <= req_tag;
		end
	end

	////////////////////
	// Memory address
	////////////////////

	// Write beats use the stored tag of the outgoing line
	// Fetch beats use the request tag
	always_comb begin
		if (mem_wen) begin
			mem_addr = {tags[wb_idx][wb_way], wb_idx, word_sel, {BYTE_OFF_W{1'b0}}};
		end else begin
			mem_addr = {req_tag, req_idx, word_sel, {BYTE_OFF_W{1'b0}}};
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps --top-module dcache_tb \
		-f dcache.f -o dcache_sim \
	&& ./obj_dir/dcache_sim \
	|| { echo "dcache build or simulation failed"; exit 1; }

// File: testbench/dcache_checker.sv
`default_nettype none

module dcache_checker (
	input logic CLK,
	input logic nRST,
	input logic dhit,
	input logic flushed,
	input logic mem_ren,
	input logic mem_wen
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// Bus rules
	////////////////////

	// One kind of memory beat at a time
	a_single_request : assert property (
		@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
	) else $error("mem_ren and mem_wen are high together");

	// Hits are served from the arrays only
	a_hit_quiet_bus : assert property (
		@(posedge CLK) disable iff (!nRST) dhit |-> !mem_ren && !mem_wen
	) else $error("dhit while a memory request is up");

	////////////////////
	// Flush rules
	////////////////////

	// A flushed cache is idle on both sides
	a_flushed_idle : assert property (
		@(posedge CLK) disable iff (!nRST) flushed |-> !mem_ren && !mem_wen && !dhit
	) else $error("activity after flushed");

	// Only reset clears flushed
	a_flushed_sticky : assert property (
		@(posedge CLK) disable iff (!nRST) flushed |=> flushed
	) else $error("flushed dropped without reset");

endmodule

`default_nettype wire

// File: testbench/dcache_tb.sv
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// About 30 accesses of up to 4 beats of 5 cycles each and a 16 line flush
	// take under 1000 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic  CLK        = 1'b0;
	logic  nRST       = 1'b0;
	logic  halt       = 1'b0;
	logic  dmem_ren   = 1'b0;
	logic  dmem_wen   = 1'b0;
	word_t dmem_addr  = '0;
	word_t dmem_store = '0;
	logic  mem_wait   = 1'b1;
	word_t mem_load   = '0;
	logic  dhit;
	logic  flushed;
	logic  mem_ren;
	logic  mem_wen;
	word_t dmem_load;
	word_t mem_addr;
	word_t mem_store;

	// Memory contents, expected values and write-back log
	word_t mem [word_t];
	word_t shadow [word_t];
	word_t wb_addr [$];
	word_t wb_data [$];
	int    wb_rd_at [$];
	int    wait_left = 0;
	int    rd_cnt    = 0;
	int    cycles    = 0;

	always #20 CLK = !CLK;

	dcache u_dcache (.*);

	bind dcache dcache_checker u_checker (
		.CLK     (CLK),
		.nRST    (nRST),
		.dhit    (dhit),
		.flushed (flushed),
		.mem_ren (mem_ren),
		.mem_wen (mem_wen)
	);

	////////////////////
	// Memory model
	////////////////////

	// Untouched words hold the address rotated by 16 and xored with a constant
	function automatic word_t preset_word(input word_t a);
		return {a[15:0], a[31:16]} ^ 32'h6b3d_91c5;
	endfunction

	function automatic word_t mem_read(input word_t a);
		return mem.exists(a) ? mem[a] : preset_word(a);
	endfunction

	function automatic word_t expected_word(input word_t a);
		return shadow.exists(a) ? shadow[a] : preset_word(a);
	endfunction

	// mem_wait stays high 1 to 4 cycles per beat
	always @(posedge CLK) begin
		if (!nRST) begin
			mem_wait <= 1'b1;
		end else if (mem_ren || mem_wen) begin
			if (!mem_wait) begin
				// Beat completes on this edge
				if (mem_wen) begin
					mem[mem_addr] = mem_store;
					wb_addr.push_back(mem_addr);
					wb_data.push_back(mem_store);
					wb_rd_at.push_back(rd_cnt);
				end else begin
					rd_cnt++;
				end
				mem_wait  <= 1'b1;
				wait_left = $urandom % 4;
			end else if (wait_left == 0) begin
				mem_wait <= 1'b0;
				mem_load <= mem_read(mem_addr);
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("TESTS FAILED");
			$fatal(1, "timeout, tests still running after %0d cycles", cycles);
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "stopping at the first wrong value");
		end
	endtask

	function automatic word_t make_addr(input tag_t tag, input idx_t idx, input logic off);
		return {tag, idx, off, 2'b00};
	endfunction

	// Request held until dhit, which is sampled mid-cycle
	task automatic access(input logic wr, input word_t addr, input word_t data,
			output word_t rdata);
		@(posedge CLK);
		dmem_ren   <= !wr;
		dmem_wen   <= wr;
		dmem_addr  <= addr;
		dmem_store <= data;
		do begin
			@(negedge CLK);
		end while (!dhit);
		rdata = dmem_load;
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
		if (wr) begin
			shadow[addr] = data;
		end
	endtask

	task automatic read_expect(input word_t addr, input string what);
		word_t rdata;
		access(1'b0, addr, '0, rdata);
		check(rdata, expected_word(addr), what);
	endtask

	task automatic write_word(input word_t addr, input word_t data);
		word_t unused;
		access(1'b1, addr, data, unused);
	endtask

	// Beats seen by memory since a snapshot
	task automatic check_traffic(input int rd0, input int wr0, input int reads,
			input int writes, input string what);
		check(word_t'(rd_cnt - rd0), word_t'(reads), {what, " memory reads"});
		check(word_t'(wb_addr.size() - wr0), word_t'(writes), {what, " memory writes"});
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic miss_then_hit();
		word_t a;
		int    rd0;
		int    wr0;
		a   = make_addr(26'h10, 3'd3, 1'b0);
		rd0 = rd_cnt;
		wr0 = wb_addr.size();
		read_expect(a, "cold read");
		check_traffic(rd0, wr0, 2, 0, "cold miss");
		rd0 = rd_cnt;
		read_expect(a, "repeat read");
		read_expect(a + 32'd4, "second word of block");
		check_traffic(rd0, wr0, 0, 0, "read hits");
	endtask

	task automatic write_hit();
		word_t a;
		int    rd0;
		int    wr0;
		a   = make_addr(26'h10, 3'd3, 1'b1);
		rd0 = rd_cnt;
		wr0 = wb_addr.size();
		write_word(a, 32'h1111_2222);
		read_expect(a, "read after write hit");
		check_traffic(rd0, wr0, 0, 0, "write hit");
	endtask

	// A, B, A, C in set 5 leaves B as the victim
	task automatic lru_eviction();
		word_t a;
		word_t b;
		word_t c;
		int    rd0;
		int    wr0;
		a = make_addr(26'h1, 3'd5, 1'b0);
		b = make_addr(26'h2, 3'd5, 1'b0);
		c = make_addr(26'h3, 3'd5, 1'b0);
		read_expect(a, "fill A");
		read_expect(b, "fill B");
		read_expect(a, "touch A");
		read_expect(c, "fill C");
		rd0 = rd_cnt;
		wr0 = wb_addr.size();
		read_expect(a, "A kept");
		check_traffic(rd0, wr0, 0, 0, "A after C");
		rd0 = rd_cnt;
		read_expect(b, "B refetched");
		check_traffic(rd0, wr0, 2, 0, "B after eviction");
	endtask

	task automatic dirty_writeback();
		word_t a0;
		word_t a1;
		word_t b;
		word_t c;
		int    rd0;
		int    wr0;
		a0 = make_addr(26'h4, 3'd6, 1'b0);
		a1 = make_addr(26'h4, 3'd6, 1'b1);
		b  = make_addr(26'h5, 3'd6, 1'b0);
		c  = make_addr(26'h6, 3'd6, 1'b0);
		write_word(a0, $urandom);
		write_word(a1, $urandom);
		// B fills the free way and leaves A as LRU
		read_expect(b, "fill B");
		rd0 = rd_cnt;
		wr0 = wb_addr.size();
		read_expect(c, "C replaces dirty A");
		check_traffic(rd0, wr0, 2, 2, "dirty eviction");
		check(wb_addr[wr0], a0, "first write-back address");
		check(wb_data[wr0], shadow[a0], "first write-back data");
		check(wb_addr[wr0+1], a1, "second write-back address");
		check(wb_data[wr0+1], shadow[a1], "second write-back data");
		check(word_t'(wb_rd_at[wr0+1]), word_t'(rd0), "fetch started before write-back");
		read_expect(a0, "A word 0 after write-back");
		read_expect(a1, "A word 1 after write-back");
	endtask

	// Every word written before the halt must be in memory once flushed
	task automatic halt_flush();
		word_t r;
		word_t a;
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			a = make_addr(tag_t'(32'h40 + i), idx_t'(i * 3), r[0]);
			write_word(a, $urandom);
		end
		@(posedge CLK);
		halt <= 1'b1;
		do begin
			@(negedge CLK);
		end while (!flushed);
		foreach (shadow[k]) begin
			check(mem_read(k), shadow[k], $sformatf("flushed word at %h", k));
		end
	endtask

	initial begin
		void'($urandom(87));
		repeat (16) @(posedge CLK);
		nRST <= 1'b1;
		miss_then_hit();
		write_hit();
		lru_eviction();
		dirty_writeback();
		halt_flush();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
